/* all.f */
logic/fetch_pkg.sv
logic/flow_ctrl.sv
logic/pc_gen.sv
logic/icache.sv
logic/pipe_stage.sv
logic/fetch_pipe_top.sv
testbench/flow_ctrl_properties.sv
testbench/fetch_pipe_tb.sv

/* logic/fetch_pipe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_pipe_top import fetch_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              id_jump_i,
    input  wire [xlen-1:0]   id_jump_pc_i,
    input  wire              ex_branch_i,
    input  wire [xlen-1:0]   ex_branch_pc_i,
    input  wire              mem_req_i,
    input  wire              dmem_ready_i,
    input  wire              ram_ready_i,
    input  wire              rom_ready_i,
    input  wire [xlen-1:0]   rom_data_i,
    output logic             rom_req_o,
    output logic [xlen-1:0]  rom_addr_o,
    output logic             ex_valid_o,
    output logic [xlen-1:0]  ex_pc_o,
    output logic [xlen-1:0]  ex_inst_o
);

    flow_cmd_t       cmd;
    logic [xlen-1:0] fetch_pc;
    logic            ic_hit;
    logic [xlen-1:0] ic_inst;
    logic            fetch_valid;

    if_id_t          if_id_in;
    if_id_t          if_id_out;
    logic            if_id_valid_in;
    logic            if_id_valid;
    logic            if_id_hold;
    logic            if_id_flush;

    id_ex_t          id_ex_in;
    id_ex_t          id_ex_out;
    logic            id_ex_valid;
    logic            id_ex_hold;
    logic            id_ex_flush;

    flow_ctrl flow_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_jump_i      (id_jump_i),
        .id_jump_pc_i   (id_jump_pc_i),
        .ex_branch_i    (ex_branch_i),
        .ex_branch_pc_i (ex_branch_pc_i),
        .fetch_valid_i  (fetch_valid),
        .ic_hit_i       (ic_hit),
        .rom_ready_i    (rom_ready_i),
        .mem_req_i      (mem_req_i),
        .dmem_ready_i   (dmem_ready_i),
        .ram_ready_i    (ram_ready_i),
        .cmd_o          (cmd)
    );

    pc_gen pc_gen_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd_i (cmd),
        .pc_o  (fetch_pc)
    );

    icache icache_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_i          (fetch_pc),
        .cmd_i         (cmd),
        .rom_ready_i   (rom_ready_i),
        .rom_data_i    (rom_data_i),
        .hit_o         (ic_hit),
        .inst_o        (ic_inst),
        .fetch_valid_o (fetch_valid),
        .rom_req_o     (rom_req_o),
        .rom_addr_o    (rom_addr_o)
    );

    // IF/ID waits on both the icache and the memory stage
    assign if_id_hold     = cmd.stall_fetch | cmd.stall_all;
    assign if_id_flush    = cmd.flush_if_id;
    assign if_id_valid_in = fetch_valid & ~cmd.stall_fetch;
    assign if_id_in       = '{pc: fetch_pc, inst: ic_inst};

    pipe_stage #(.payload_t(if_id_t)) if_id_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (if_id_hold),
        .flush_i (if_id_flush),
        .valid_i (if_id_valid_in),
        .data_i  (if_id_in),
        .valid_o (if_id_valid),
        .data_o  (if_id_out)
    );

    assign id_ex_hold  = cmd.stall_all;
    assign id_ex_flush = cmd.flush_id_ex;   // taken branch only
    assign id_ex_in    = '{pc: if_id_out.pc, inst: if_id_out.inst};

    pipe_stage #(.payload_t(id_ex_t)) id_ex_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (id_ex_hold),
        .flush_i (id_ex_flush),
        .valid_i (if_id_valid),
        .data_i  (id_ex_in),
        .valid_o (id_ex_valid),
        .data_o  (id_ex_out)
    );

    assign ex_valid_o = id_ex_valid;
    assign ex_pc_o    = id_ex_out.pc;
    assign ex_inst_o  = id_ex_out.inst;

endmodule

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam int unsigned xlen = 32;

    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam logic [xlen-1:0] pc_step  = 32'd4;

    // instruction cache geometry, one word per line
    localparam int unsigned ic_lines   = 8;
    localparam int unsigned ic_index_w = 3;
    localparam int unsigned ic_tag_w   = xlen - ic_index_w - 2;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } if_id_t;

    // kept apart from if_id_t, grows once decode fields are added
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } id_ex_t;

    typedef struct packed {
        logic            jump;        // redirect fetch to jump_pc
        logic [xlen-1:0] jump_pc;
        logic            flush_if_id;
        logic            flush_id_ex;
        logic            stall_fetch; // icache miss pending
        logic            stall_all;   // data memory wait
    } flow_cmd_t;

endpackage

`default_nettype wire

/* logic/flow_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_ctrl import fetch_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             id_jump_i,
    input  wire [xlen-1:0]  id_jump_pc_i,
    input  wire             ex_branch_i,
    input  wire [xlen-1:0]  ex_branch_pc_i,
    input  wire             fetch_valid_i,
    input  wire             ic_hit_i,
    input  wire             rom_ready_i,
    input  wire             mem_req_i,
    input  wire             dmem_ready_i,
    input  wire             ram_ready_i,
    output flow_cmd_t       cmd_o
);

    logic rom_ready_q;
    logic ram_ready_q;
    logic rom_rise;
    logic ram_rise;
    logic redirect;
    logic fetch_miss;
    logic stall_fetch_q;
    logic stall_all_q;

    assign rom_rise = rom_ready_i & ~rom_ready_q; // refill done
    assign ram_rise = ram_ready_i & ~ram_ready_q;
    assign redirect = ex_branch_i | id_jump_i;

    // a miss on a path about to be redirected is not worth waiting for
    assign fetch_miss = fetch_valid_i & ~ic_hit_i & ~redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_ready_q <= 1'b0;
            ram_ready_q <= 1'b0;
        end else begin
            rom_ready_q <= rom_ready_i;
            ram_ready_q <= ram_ready_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_fetch_q <= 1'b0;
        end else if (redirect) begin
            stall_fetch_q <= 1'b0;  // drop the wrong-path miss
        end else if (fetch_miss) begin
            stall_fetch_q <= 1'b1;
        end else if (rom_rise) begin
            stall_fetch_q <= 1'b0;
        end
    end

    // memory stage keeps the front end frozen until the RAM answers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_all_q <= 1'b0;
        end else if (ram_rise) begin
            stall_all_q <= 1'b0;
        end else if (mem_req_i && !dmem_ready_i) begin
            stall_all_q <= 1'b1;
        end
    end

    always_comb begin
        cmd_o.jump        = redirect;
        cmd_o.jump_pc     = ex_branch_i ? ex_branch_pc_i :   // branch wins
                            id_jump_i   ? id_jump_pc_i   : '0;
        cmd_o.flush_if_id = redirect;
        cmd_o.flush_id_ex = ex_branch_i;
        // the miss itself also holds, so the missing address is not stepped over
        cmd_o.stall_fetch = (stall_fetch_q & ~rom_rise & ~redirect) | fetch_miss;
        cmd_o.stall_all   = stall_all_q;
    end

endmodule

`default_nettype wire

/* logic/icache.sv */
`timescale 1ns/100ps
`default_nettype none

module icache import fetch_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire [xlen-1:0]   pc_i,
    input  wire flow_cmd_t   cmd_i,
    input  wire              rom_ready_i,
    input  wire [xlen-1:0]   rom_data_i,
    output logic             hit_o,
    output logic [xlen-1:0]  inst_o,
    output logic             fetch_valid_o,
    output logic             rom_req_o,
    output logic [xlen-1:0]  rom_addr_o
);

    logic [ic_tag_w-1:0]   tag_mem  [ic_lines];
    logic [xlen-1:0]       data_mem [ic_lines];
    logic [ic_lines-1:0]   valid_q;

    logic [ic_index_w-1:0] index;
    logic [ic_tag_w-1:0]   tag;
    logic                  tag_hit;
    logic                  refilling_q;
    logic [xlen-3:0]       miss_line_q; // word address under refill
    logic [ic_index_w-1:0] fill_index;
    logic                  rom_ready_q;
    logic                  rom_rise;
    logic                  fill_write;
    logic                  fill_match;

    assign index   = pc_i[ic_index_w+1:2];
    assign tag     = pc_i[xlen-1:ic_index_w+2];
    assign tag_hit = valid_q[index] && (tag_mem[index] == tag);

    assign fill_index = miss_line_q[ic_index_w-1:0];
    assign rom_rise   = rom_ready_i & ~rom_ready_q;
    assign fill_write = refilling_q & rom_rise & ~cmd_i.jump;

    // returning word goes straight to IF/ID, saves a cycle
    assign fill_match = fill_write & (pc_i[xlen-1:2] == miss_line_q);

    assign hit_o         = (~refilling_q & tag_hit) | fill_match;
    assign inst_o        = fill_match ? rom_data_i : data_mem[index];
    assign fetch_valid_o = ~refilling_q | rom_rise;
    assign rom_req_o     = refilling_q;
    assign rom_addr_o    = {miss_line_q, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refilling_q <= 1'b0;
            rom_ready_q <= 1'b0;
            valid_q     <= '0;
        end else begin
            rom_ready_q <= rom_ready_i;
            if (refilling_q) begin
                if (cmd_i.jump) begin
                    refilling_q <= 1'b0;          // abandoned, nothing written
                end else if (rom_rise) begin
                    refilling_q         <= 1'b0;
                    valid_q[fill_index] <= 1'b1;
                end
            end else if (!tag_hit && !cmd_i.jump) begin
                refilling_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!refilling_q && !tag_hit) begin
            miss_line_q <= pc_i[xlen-1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_mem[fill_index]  <= miss_line_q[xlen-3:ic_index_w];
            data_mem[fill_index] <= rom_data_i;
        end
    end

endmodule

`default_nettype wire

/* logic/pc_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_gen import fetch_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire flow_cmd_t   cmd_i,
    output logic [xlen-1:0]  pc_o
);

    logic hold;

    assign hold = cmd_i.stall_fetch | cmd_i.stall_all;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o <= reset_pc;
        end else if (cmd_i.jump) begin
            pc_o <= cmd_i.jump_pc;       // jump or taken branch
        end else if (!hold) begin
            pc_o <= pc_o + pc_step;
        end
    end

endmodule

`default_nettype wire

/* logic/pipe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            hold_i,
    input  wire            flush_i,
    input  wire            valid_i,
    input  wire payload_t  data_i,
    output logic           valid_o,
    output payload_t       data_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;    // flush beats hold
        end else if (!hold_i) begin
            valid_o <= valid_i;
        end
    end

    // payload only matters while valid_o is set
    always_ff @(posedge clk) begin
        if (!hold_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

/* testbench/fetch_patterns.txt */
// word 0 event count, word 1 expected pc count; then kind trigger_pc argument per event
// kinds: 1 jump (trigger pc in decode), 2 branch, 3 branch with competing jump,
// 4 memory wait (argument cycles), 5 no rom request (argument cycles); then expected pcs
00000007 00000017
00000002 00000010 00000000
00000005 00000000 00000003
00000001 00000010 00000020
00000004 00000024 00000006
00000003 0000002c 00000080
00000004 00000084 00000001
00000001 00000094 00000100
// first pass, cold misses
00000000 00000004 00000008 0000000c 00000010
// second pass from cache
00000000 00000004 00000008 0000000c 00000010
00000020 00000024 00000028 0000002c
00000080 00000084 00000088 0000008c 00000090 00000094
00000100 00000104 00000108

/* testbench/fetch_pipe_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_pipe_tb import fetch_pkg::*; ();

    localparam int unsigned clk_period       = 20;
    localparam int unsigned drive_delay      = 2;
    localparam int unsigned reset_cycles     = 16;
    localparam int unsigned cycles_per_event = 40;
    localparam logic [xlen-1:0] decoy_pc     = 32'h0000_0200; // jump that must lose

    // event kinds of the pattern file
    localparam logic [xlen-1:0] ev_jump        = 1;
    localparam logic [xlen-1:0] ev_branch      = 2;
    localparam logic [xlen-1:0] ev_branch_jump = 3;
    localparam logic [xlen-1:0] ev_mem_wait    = 4;
    localparam logic [xlen-1:0] ev_no_refill   = 5;

    logic            clk;
    logic            rst_n;
    logic            id_jump;
    logic [xlen-1:0] id_jump_pc;
    logic            ex_branch;
    logic [xlen-1:0] ex_branch_pc;
    logic            mem_req;
    logic            dmem_ready;
    logic            ram_ready;
    logic            rom_ready;
    logic [xlen-1:0] rom_data;
    logic            rom_req;
    logic [xlen-1:0] rom_addr;
    logic            ex_valid;
    logic [xlen-1:0] ex_pc;
    logic [xlen-1:0] ex_inst;

    logic [xlen-1:0] pattern_mem [0:63];
    int              n_events;
    int              n_expected;
    int              checked;
    int              error_count;
    logic            events_done;
    logic            seen_valid;
    logic [xlen-1:0] last_pc;
    integer          seed;

    // decode is not a port, jumps trigger on it
    logic            id_valid;
    logic [xlen-1:0] id_pc;
    assign id_valid = fetch_pipe_top_inst.if_id_valid;
    assign id_pc    = fetch_pipe_top_inst.if_id_out.pc;

    fetch_pipe_top fetch_pipe_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_jump_i      (id_jump),
        .id_jump_pc_i   (id_jump_pc),
        .ex_branch_i    (ex_branch),
        .ex_branch_pc_i (ex_branch_pc),
        .mem_req_i      (mem_req),
        .dmem_ready_i   (dmem_ready),
        .ram_ready_i    (ram_ready),
        .rom_ready_i    (rom_ready),
        .rom_data_i     (rom_data),
        .rom_req_o      (rom_req),
        .rom_addr_o     (rom_addr),
        .ex_valid_o     (ex_valid),
        .ex_pc_o        (ex_pc),
        .ex_inst_o      (ex_inst)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at time %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #drive_delay;
    endtask

    function automatic logic event_triggered(input logic [xlen-1:0] kind,
                                             input logic [xlen-1:0] trig_pc);
        if (kind == ev_jump) begin
            return (id_valid === 1'b1) && (id_pc === trig_pc);
        end
        return (ex_valid === 1'b1) && (ex_pc === trig_pc);
    endfunction

    task automatic apply_event(input logic [xlen-1:0] kind, input logic [xlen-1:0] arg);
        case (kind)
            ev_jump: begin
                id_jump    = 1'b1;
                id_jump_pc = arg;
                next_drive_slot();
                id_jump    = 1'b0;
            end
            ev_branch, ev_branch_jump: begin
                ex_branch    = 1'b1;
                ex_branch_pc = arg;
                id_jump      = (kind == ev_branch_jump);
                id_jump_pc   = decoy_pc;
                next_drive_slot();
                ex_branch    = 1'b0;
                id_jump      = 1'b0;
            end
            ev_mem_wait: begin
                mem_req    = 1'b1;
                dmem_ready = 1'b0;
                next_drive_slot();
                mem_req    = 1'b0;
                dmem_ready = 1'b1;
                repeat (arg) next_drive_slot();
                ram_ready  = 1'b1;  // one-cycle answer from the RAM
                next_drive_slot();
                ram_ready  = 1'b0;
            end
            ev_no_refill: begin
                for (int n = 0; n < arg; n++) begin
                    if (n > 0) next_drive_slot();
                    check_value("rom_req_o", '0, rom_req);
                end
            end
            default: begin
                $display("pattern file holds an unknown event kind %h", kind);
                $display("Regression failed");
                $fatal(1, "bad pattern file");
            end
        endcase
    endtask

    task automatic compare_output();
        logic [xlen-1:0] expected_pc;
        if (checked >= n_expected) begin
            $display("unexpected extra instruction at pc %h left execute at %0t", ex_pc, $time);
            $display("Regression failed");
            $fatal(1, "too many instructions");
        end else begin
            expected_pc = pattern_mem[2 + 3 * n_events + checked];
            check_value("ex_pc_o", expected_pc, ex_pc);
            check_value("ex_inst_o", ~expected_pc, ex_inst);  // rom word is ~address
            checked++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        id_jump      = 1'b0;
        id_jump_pc   = '0;
        ex_branch    = 1'b0;
        ex_branch_pc = '0;
        mem_req      = 1'b0;
        dmem_ready   = 1'b1;
        ram_ready    = 1'b0;
        rom_ready    = 1'b0;
        rom_data     = '0;
        seed         = 49;
        checked      = 0;
        error_count  = 0;
        $readmemh("testbench/fetch_patterns.txt", pattern_mem);
        if ($isunknown(pattern_mem[0]) || $isunknown(pattern_mem[1])) begin
            $display("pattern file testbench/fetch_patterns.txt could not be read");
            $display("Regression failed");
            $fatal(1, "no stimulus");
        end
        n_events   = pattern_mem[0];
        n_expected = pattern_mem[1];
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        wait (events_done === 1'b1 && checked == n_expected);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // events run in file order, each waits for its trigger pc
    initial begin : event_driver
        logic [xlen-1:0] kind;
        logic [xlen-1:0] trig_pc;
        events_done = 1'b0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < n_events; i++) begin
            kind    = pattern_mem[2 + 3 * i];
            trig_pc = pattern_mem[3 + 3 * i];
            do begin
                next_drive_slot();
            end while (!event_triggered(kind, trig_pc));
            apply_event(kind, pattern_mem[4 + 3 * i]);
        end
        events_done = 1'b1;
    end

    initial begin : rom_model
        logic        busy;
        int unsigned wait_left;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            next_drive_slot();
            rom_ready = 1'b0;
            rom_data  = '0;
            if (rst_n !== 1'b1 || rom_req !== 1'b1) begin
                busy = 1'b0;                // request dropped or abandoned
            end else if (!busy) begin
                busy      = 1'b1;
                wait_left = 2 + ($unsigned($random(seed)) % 5);
            end else begin
                wait_left--;
                if (wait_left == 0) begin
                    rom_ready = 1'b1;
                    rom_data  = ~rom_addr;
                    busy      = 1'b0;
                end
            end
        end
    end

    // held instructions repeat on ex_valid_o, only new pcs count
    always @(negedge clk) begin
        if (rst_n === 1'b1 && ex_valid === 1'b1) begin
            if (!(seen_valid === 1'b1 && ex_pc === last_pc)) begin
                compare_output();
            end
            last_pc = ex_pc;
        end
        seen_valid = (rst_n === 1'b1) && (ex_valid === 1'b1);
    end

    initial begin : watchdog
        wait (rst_n === 1'b1);
        repeat (n_events * cycles_per_event) @(posedge clk);
        $display("timeout: %0d of %0d instructions seen after %0d cycles",
                 checked, n_expected, n_events * cycles_per_event);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* testbench/flow_ctrl_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_ctrl_properties import fetch_pkg::*; (
    input wire            clk,
    input wire            rst_n,
    input wire flow_cmd_t cmd_i,
    input wire            ram_ready_i,
    input wire            stall_fetch_flag_i,
    input wire            stall_all_flag_i
);

    redirect_without_stall: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_i.jump |=> !stall_fetch_flag_i
    ) else $error("stall_fetch pending in the cycle after a redirect");

    // a taken branch always clears decode as well
    branch_flushes_both: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_i.flush_id_ex |-> cmd_i.flush_if_id
    ) else $error("flush_id_ex raised without flush_if_id");

    stall_all_release: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(cmd_i.stall_all) |-> ($past(ram_ready_i) && !$past(ram_ready_i, 2))
    ) else $error("stall_all cleared without a ram_ready_i rise");

    // the empty cache reports a miss even in reset, so the stall flops are checked
    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !(cmd_i.jump || cmd_i.flush_if_id || cmd_i.flush_id_ex
                                   || stall_fetch_flag_i || stall_all_flag_i)
    ) else $error("flow command active during reset");

endmodule

bind flow_ctrl flow_ctrl_properties flow_ctrl_properties_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .cmd_i              (cmd_o),
    .ram_ready_i        (ram_ready_i),
    .stall_fetch_flag_i (stall_fetch_q),
    .stall_all_flag_i   (stall_all_q)
);

`default_nettype wire
